// File: sources.f
rtl/bp_pkg.sv
rtl/branch_table.sv
rtl/return_stack.sv
rtl/next_pc_select.sv
rtl/branch_predict_top.sv
dv/bp_checker.sv
dv/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the predictor testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_top \
    -o sim_bp > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/sim_bp > sim.log 2>&1 || { cat sim.log; echo "Run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// File: dv/tb_top.sv
// Testbench for the next-PC predictor, playing execute and instruction memory.
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam int table_entries = 64;
    localparam int ras_depth = 8;
    localparam bit use_predictor = 1'b1;
    localparam int reset_cycles = 16;
    localparam int wait_limit = 400;                    // Cycles per wait.
    localparam int random_res = 2000;
    localparam int budget_cycles = reset_cycles + 40 + 24 * wait_limit + random_res * 4;
    localparam int margin_cycles = 1000;

    logic           clk;
    logic           rst;
    logic           fetch_valid;
    bp_pkg::addr_t  fetch_pc;
    logic           fetch_ready;
    logic           res_valid;
    bp_pkg::addr_t  res_pc;
    logic           res_taken;
    bp_pkg::addr_t  res_target;
    logic           res_is_call;
    logic           res_is_return;
    bp_pkg::addr_t  res_next_pc;
    logic           flush;
    bp_pkg::addr_t  redirect_pc;
    bp_pkg::count_t mispredict_branch_count;
    bp_pkg::count_t mispredict_return_count;
    int             chk_errors;
    int             chk_checks;
    int             tb_errors = 0;
    int             depth = 0;                          // Outstanding calls.
    int             test_no = 0;
    int             errors_before = 0;
    bp_pkg::count_t exp_branch = '0;
    bp_pkg::count_t exp_return = '0;

    // ************************************************************
    // Clock, back-pressure, watchdog
    // ************************************************************
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        fetch_ready = ($urandom % 4) != 0;              // Stall about one cycle in four.
    end

    initial begin
        #((budget_cycles + margin_cycles) * 10);
        $display("Watchdog expired before the tests completed");
        $display("Simulation failed");
        $finish;
    end

    branch_predict_top #(
        .table_entries (table_entries),
        .ras_depth     (ras_depth),
        .use_predictor (use_predictor)
    ) i_dut (
        .clk (clk), .rst (rst),
        .fetch_valid (fetch_valid), .fetch_pc (fetch_pc), .fetch_ready (fetch_ready),
        .res_valid (res_valid), .res_pc (res_pc), .res_taken (res_taken),
        .res_target (res_target), .res_is_call (res_is_call),
        .res_is_return (res_is_return), .res_next_pc (res_next_pc),
        .flush (flush), .redirect_pc (redirect_pc),
        .mispredict_branch_count (mispredict_branch_count),
        .mispredict_return_count (mispredict_return_count)
    );

    bp_checker #(
        .table_entries (table_entries),
        .ras_depth     (ras_depth),
        .use_predictor (use_predictor)
    ) i_checker (
        .clk (clk), .rst (rst),
        .fetch_valid (fetch_valid), .fetch_ready (fetch_ready), .fetch_pc (fetch_pc),
        .res_valid (res_valid), .res_pc (res_pc), .res_taken (res_taken),
        .res_target (res_target), .res_is_call (res_is_call),
        .res_is_return (res_is_return), .res_next_pc (res_next_pc),
        .flush (flush), .redirect_pc (redirect_pc),
        .mispredict_branch_count (mispredict_branch_count),
        .mispredict_return_count (mispredict_return_count),
        .error_count (chk_errors), .check_count (chk_checks)
    );

    // ************************************************************
    // Execute side tasks
    // ************************************************************
    // One resolution cycle; expected counter totals follow the misprediction rule.
    task automatic resolve(input bp_pkg::addr_t pc, input logic taken,
        input bp_pkg::addr_t target, input logic is_call, input logic is_ret,
        input bp_pkg::addr_t next_pc);
        bp_pkg::addr_t good;
        good = taken ? target : pc + 32'd4;
        res_pc = pc;
        res_taken = taken;
        res_target = target;
        res_is_call = is_call;
        res_is_return = is_ret;
        res_next_pc = next_pc;
        res_valid = 1'b1;
        if (next_pc != good && is_ret) begin
            exp_return++;
        end else if (next_pc != good) begin
            exp_branch++;
        end
        if (is_call && depth < ras_depth) begin
            depth++;
        end else if (is_ret && depth > 0) begin
            depth--;
        end
        @(posedge clk);
        #1;
        res_valid = 1'b0;
    endtask

    // Wait for an accepted fetch, of a given PC or of any PC.
    task automatic wait_accept(input bp_pkg::addr_t pc, input logic any_pc,
        output bp_pkg::addr_t got);
        int n;
        logic found;
        n = 0;
        found = 1'b0;
        got = '0;
        while (!found && n < wait_limit) begin
            @(posedge clk);
            if (fetch_valid && fetch_ready && (any_pc || fetch_pc == pc)) begin
                found = 1'b1;
                got = fetch_pc;
            end
            n++;
        end
        #1;
        if (!found) begin
            tb_errors++;
            $display("Test %0d: no fetch was accepted as awaited within %0d cycles",
                     test_no + 1, wait_limit);
        end
    endtask

    task automatic expect_next(input bp_pkg::addr_t exp);
        bp_pkg::addr_t got;
        wait_accept('0, 1'b1, got);
        if (got !== exp) begin
            tb_errors++;
            $display("ERROR t=%0t fetch_pc expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic check_counts();
        if (mispredict_branch_count !== exp_branch) begin
            tb_errors++;
            $display("ERROR t=%0t mispredict_branch_count expected %h got %h",
                     $time, exp_branch, mispredict_branch_count);
        end
        if (mispredict_return_count !== exp_return) begin
            tb_errors++;
            $display("ERROR t=%0t mispredict_return_count expected %h got %h",
                     $time, exp_return, mispredict_return_count);
        end
    endtask

    task automatic end_test(input string name);
        test_no++;
        $display("Test %0d %s done with %0d errors", test_no, name,
                 tb_errors + chk_errors - errors_before);
        errors_before = tb_errors + chk_errors;
    endtask

    // ************************************************************
    // Test sequence
    // ************************************************************
    initial begin
        bp_pkg::addr_t pc;
        bp_pkg::addr_t target;
        bp_pkg::addr_t good;
        bp_pkg::addr_t next;
        bp_pkg::addr_t dummy;
        logic          taken;
        logic          is_call;
        logic          is_ret;
        int            kind;
        int            gap;
        void'($urandom(32'h5a31));
        rst = 1'b1;
        fetch_ready = 1'b0;
        res_valid = 1'b0;
        res_pc = '0;
        res_taken = 1'b0;
        res_target = '0;
        res_is_call = 1'b0;
        res_is_return = 1'b0;
        res_next_pc = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (40) @(posedge clk);                     // Sequential fetch only.
        #1;
        end_test("sequential fetch");

        resolve(32'h220, 1'b1, 32'h200, 1'b0, 1'b0, 32'h224);
        wait_accept(32'h220, 1'b0, dummy);
        expect_next(32'h200);                           // Taken entry.
        resolve(32'h220, 1'b0, 32'h200, 1'b0, 1'b0, 32'h200);
        expect_next(32'h224);
        end_test("taken and not-taken entries");

        resolve(32'h420, 1'b1, 32'h500, 1'b0, 1'b0, 32'h500);
        wait_accept(32'h320, 1'b0, dummy);
        expect_next(32'h324);                           // Alias gets no hit.
        wait_accept(32'h420, 1'b0, dummy);
        expect_next(32'h500);
        end_test("tag mismatch");

        resolve(32'h500, 1'b1, 32'h200, 1'b0, 1'b0, 32'h504);
        expect_next(32'h200);                           // Redirect first.
        check_counts();
        wait_accept(32'h220, 1'b0, dummy);
        expect_next(32'h224);
        end_test("misprediction redirect");

        resolve(32'h260, 1'b1, 32'h600, 1'b1, 1'b0, 32'h600);
        resolve(32'h260, 1'b1, 32'h600, 1'b1, 1'b0, 32'h600);
        resolve(32'h604, 1'b1, 32'h264, 1'b0, 1'b1, 32'h264);
        wait_accept(32'h604, 1'b0, dummy);
        expect_next(32'h264);                           // From the stack.
        resolve(32'h604, 1'b1, 32'h264, 1'b0, 1'b1, 32'h700);
        expect_next(32'h264);
        check_counts();
        end_test("return stack");

        for (int i = 0; i < random_res; i++) begin
            pc = bp_pkg::reset_vec + (($urandom % 256) << 2);
            target = bp_pkg::reset_vec + (($urandom % 256) << 2);
            kind = $urandom % 8;
            is_call = (kind == 0);
            is_ret = (kind == 1) && (depth > 0);        // Never pop an empty stack.
            taken = (is_call || is_ret) ? 1'b1 : 1'($urandom % 2);
            good = taken ? target : pc + 32'd4;
            next = ($urandom % 4 == 0) ? good + 32'd8 : good;
            resolve(pc, taken, target, is_call, is_ret, next);
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        check_counts();
        end_test("random resolutions");

        $display("Tests %0d, checks %0d, errors %0d", test_no, chk_checks,
                 tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/bp_checker.sv
// Predictor scoreboard that models table, stack and fetch PC and compares DUT outputs.
`timescale 1ns/1ns
`default_nettype none

module bp_checker #(
    parameter int table_entries = 64,
    parameter int ras_depth = 8,
    parameter bit use_predictor = 1'b1
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_valid,
    input  logic           fetch_ready,
    input  bp_pkg::addr_t  fetch_pc,
    input  logic           res_valid,
    input  bp_pkg::addr_t  res_pc,
    input  logic           res_taken,
    input  bp_pkg::addr_t  res_target,
    input  logic           res_is_call,
    input  logic           res_is_return,
    input  bp_pkg::addr_t  res_next_pc,
    input  logic           flush,
    input  bp_pkg::addr_t  redirect_pc,
    input  bp_pkg::count_t mispredict_branch_count,
    input  bp_pkg::count_t mispredict_return_count,
    output int             error_count,
    output int             check_count
);

    localparam int idx_w = $clog2(table_entries);
    localparam int tag_lsb = 2 + idx_w;                 // First tag bit.

    logic           m_valid [table_entries];            // Model table.
    logic           m_ret [table_entries];
    bp_pkg::addr_t  m_tag [table_entries];
    bp_pkg::addr_t  m_target [table_entries];
    bp_pkg::addr_t  m_stack [ras_depth];                // Model return stack.
    int             sp;
    int             depth;
    bp_pkg::addr_t  pc_hold;                            // Model of the held PC.
    logic           pend;                               // Prediction due this cycle.
    logic           pend_valid;
    logic           pend_ret;
    bp_pkg::addr_t  pend_tag;
    bp_pkg::addr_t  pend_target;
    bp_pkg::addr_t  pend_if;
    bp_pkg::count_t exp_branch;
    bp_pkg::count_t exp_return;
    bp_pkg::addr_t  exp_pc;
    bp_pkg::addr_t  ras_now;
    bp_pkg::addr_t  good_pc;
    logic           exp_flush;
    logic           wrong;
    int             idx;
    int             errors = 0;
    int             checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // Successor the fetch should follow after an accepted address.
    function automatic bp_pkg::addr_t expected_next(input logic entry_valid,
        input logic entry_ret, input bp_pkg::addr_t entry_tag,
        input bp_pkg::addr_t entry_target, input bp_pkg::addr_t if_addr,
        input bp_pkg::addr_t stack_top);
        logic is_hit;
        is_hit = use_predictor && entry_valid && (entry_tag == (if_addr >> tag_lsb));
        if (is_hit) begin
            return entry_ret ? stack_top : entry_target;
        end
        return if_addr + 32'd4;                         // Fall through.
    endfunction

    function automatic bp_pkg::addr_t successor(input bp_pkg::addr_t pc, input logic taken,
        input bp_pkg::addr_t target);
        return taken ? target : pc + 32'd4;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
        input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // ************************************************************
    // Per-cycle compare and model update
    // ************************************************************
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < table_entries; i++) begin
                m_valid[i] = 1'b0;
            end
            sp = 0;
            depth = 0;
            pc_hold = bp_pkg::reset_vec;
            pend = 1'b0;
            exp_branch = '0;
            exp_return = '0;
        end else begin
            ras_now = (depth == 0) ? bp_pkg::reset_vec : m_stack[sp];    // Empty reads idle.
            exp_pc = pend ? expected_next(pend_valid, pend_ret, pend_tag, pend_target,
                                          pend_if, ras_now) : pc_hold;
            good_pc = successor(res_pc, res_taken, res_target);
            wrong = res_valid && (res_next_pc != good_pc);
            exp_flush = use_predictor ? wrong : (res_valid && res_taken);
            compare_value("fetch_valid", 32'd1, {31'd0, fetch_valid});
            compare_value("fetch_pc", exp_pc, fetch_pc);
            compare_value("flush", {31'd0, exp_flush}, {31'd0, flush});
            if (exp_flush) begin
                compare_value("redirect_pc", good_pc, redirect_pc);
            end
            compare_value("mispredict_branch_count", exp_branch, mispredict_branch_count);
            compare_value("mispredict_return_count", exp_return, mispredict_return_count);

            if (exp_flush) begin
                pc_hold = good_pc;                      // Redirect wins.
                pend = 1'b0;
            end else if (fetch_valid && fetch_ready) begin
                idx = int'(fetch_pc[2 +: idx_w]);       // Read before this edge's write.
                pend_valid = m_valid[idx];
                pend_ret = m_ret[idx];
                pend_tag = m_tag[idx];
                pend_target = m_target[idx];
                pend_if = fetch_pc;
                pend = 1'b1;
            end else if (pend) begin
                pc_hold = exp_pc;                       // Guess frozen under stall.
                pend = 1'b0;
            end

            if (res_valid) begin
                idx = int'(res_pc[2 +: idx_w]);
                m_valid[idx] = 1'b1;
                m_ret[idx] = res_is_return;
                m_tag[idx] = res_pc >> tag_lsb;
                m_target[idx] = good_pc;
            end
            if (wrong && res_is_return) begin
                exp_return = exp_return + 1'b1;
            end else if (wrong) begin
                exp_branch = exp_branch + 1'b1;
            end

            if (res_valid && res_is_call && res_is_return) begin
                if (depth == 0) begin
                    depth = 1;
                end
                m_stack[sp] = res_pc + 32'd4;           // Swap top in place.
            end else if (res_valid && res_is_call) begin
                sp = (sp + 1) % ras_depth;
                m_stack[sp] = res_pc + 32'd4;
                if (depth < ras_depth) begin
                    depth++;                            // Full stack loses the oldest.
                end
            end else if (res_valid && res_is_return && depth > 0) begin
                sp = (sp + ras_depth - 1) % ras_depth;
                depth--;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/branch_predict_top.sv
// Next-PC prediction front end joining branch table, return stack and PC selection.
`timescale 1ns/1ns
`default_nettype none

module branch_predict_top #(
    parameter int table_entries = 64,
    parameter int ras_depth = 8,
    parameter bit use_predictor = 1'b1
) (
    input  logic           clk,
    input  logic           rst,
    output logic           fetch_valid,
    output bp_pkg::addr_t  fetch_pc,
    input  logic           fetch_ready,
    input  logic           res_valid,
    input  bp_pkg::addr_t  res_pc,
    input  logic           res_taken,
    input  bp_pkg::addr_t  res_target,
    input  logic           res_is_call,
    input  logic           res_is_return,
    input  bp_pkg::addr_t  res_next_pc,
    output logic           flush,
    output bp_pkg::addr_t  redirect_pc,
    output bp_pkg::count_t mispredict_branch_count,
    output bp_pkg::count_t mispredict_return_count
);

    logic          fetch_accept;   // Handshake completed.
    bp_pkg::addr_t accept_pc;      // PC taken by memory.
    bp_pkg::addr_t if_pc;          // Last accepted PC.
    logic          hit;
    logic          use_ras;
    bp_pkg::addr_t predicted_pc;
    bp_pkg::addr_t ras_top;

    // *********************************************************
    // Prediction sources
    // *********************************************************
    branch_table #(
        .table_entries (table_entries),
        .use_predictor (use_predictor)
    ) i_branch_table (
        .clk                     (clk),
        .rst                     (rst),
        .fetch_accept            (fetch_accept),
        .accept_pc               (accept_pc),
        .if_pc                   (if_pc),
        .res_valid               (res_valid),
        .res_pc                  (res_pc),
        .res_taken               (res_taken),
        .res_target              (res_target),
        .res_is_return           (res_is_return),
        .res_next_pc             (res_next_pc),
        .hit                     (hit),
        .use_ras                 (use_ras),
        .predicted_pc            (predicted_pc),
        .flush                   (flush),
        .redirect_pc             (redirect_pc),
        .mispredict_branch_count (mispredict_branch_count),
        .mispredict_return_count (mispredict_return_count)
    );

    return_stack #(
        .ras_depth (ras_depth)
    ) i_return_stack (
        .clk           (clk),
        .rst           (rst),
        .res_valid     (res_valid),
        .res_is_call   (res_is_call),
        .res_is_return (res_is_return),
        .res_pc        (res_pc),
        .ras_top       (ras_top)
    );

    // *********************************************************
    // Fetch PC
    // *********************************************************
    next_pc_select i_next_pc_select (
        .clk          (clk),
        .rst          (rst),
        .fetch_ready  (fetch_ready),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_accept (fetch_accept),
        .accept_pc    (accept_pc),
        .if_pc        (if_pc),
        .hit          (hit),
        .use_ras      (use_ras),
        .predicted_pc (predicted_pc),
        .ras_top      (ras_top),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

endmodule

`default_nettype wire

// File: rtl/next_pc_select.sv
// Fetch PC register and next-PC choice with valid/ready hold toward instruction memory.
`timescale 1ns/1ns
`default_nettype none

module next_pc_select (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_ready,
    output logic          fetch_valid,
    output bp_pkg::addr_t fetch_pc,
    output logic          fetch_accept,
    output bp_pkg::addr_t accept_pc,
    output bp_pkg::addr_t if_pc,
    input  logic          hit,
    input  logic          use_ras,
    input  bp_pkg::addr_t predicted_pc,
    input  bp_pkg::addr_t ras_top,
    input  logic          flush,
    input  bp_pkg::addr_t redirect_pc
);

    bp_pkg::addr_t pc_reg;        // Held or redirected PC.
    logic          pred_pending;  // Table result for if_pc is due this cycle.
    bp_pkg::addr_t next_pred;     // Successor of if_pc.

    // *********************************************************
    // Next PC choice
    // *********************************************************
    // On a table hit a return follows the stack, other branches follow
    // the stored target. A miss falls through to the next word.
    always_comb begin
        if (hit) begin
            next_pred = use_ras ? ras_top : predicted_pc;
        end else begin
            next_pred = if_pc + bp_pkg::pc_step;
        end
    end

    assign fetch_valid = 1'b1;                                  // Always a PC to offer.
    assign fetch_pc = pred_pending ? next_pred : pc_reg;       // Fresh guess or held PC.
    assign fetch_accept = fetch_valid & fetch_ready;
    assign accept_pc = fetch_pc;                                // Table read address.

    // *********************************************************
    // PC register and hold
    // *********************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_reg <= bp_pkg::reset_vec;
            pred_pending <= 1'b0;
        end else if (flush) begin
            pc_reg <= redirect_pc;                              // Beats guess and hold.
            pred_pending <= 1'b0;
        end else if (fetch_accept) begin
            pred_pending <= 1'b1;                               // Use table next cycle.
        end else if (pred_pending) begin
            pc_reg <= next_pred;                                // Freeze guess under stall.
            pred_pending <= 1'b0;
        end
    end

    // Last accepted address, tag compare and fall-through base.
    always_ff @(posedge clk) begin
        if (rst) begin
            if_pc <= bp_pkg::reset_vec;
        end else if (fetch_accept) begin
            if_pc <= fetch_pc;
        end
    end

    // Instruction memory relies on the offered PC staying put while it stalls.
    a_stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && !fetch_ready && !flush |=> $stable(fetch_pc))
        else $error("fetch_pc changed during a stall");

endmodule

`default_nettype wire

// File: rtl/return_stack.sv
// Circular return-address stack updated by resolved calls and returns.
`timescale 1ns/1ns
`default_nettype none

module return_stack #(
    parameter int ras_depth = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          res_valid,
    input  logic          res_is_call,
    input  logic          res_is_return,
    input  bp_pkg::addr_t res_pc,
    output bp_pkg::addr_t ras_top
);

    localparam int ptr_w = (ras_depth > 1) ? $clog2(ras_depth) : 1;
    localparam int cnt_w = $clog2(ras_depth + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(ras_depth - 1);    // Wrap point.
    localparam logic [cnt_w-1:0] full_count = cnt_w'(ras_depth);

    bp_pkg::addr_t    stack_mem [ras_depth];   // Return addresses.
    logic [ptr_w-1:0] top_ptr;                 // Slot of the newest entry.
    logic [ptr_w-1:0] ptr_up;
    logic [ptr_w-1:0] ptr_dn;
    logic [cnt_w-1:0] count;                   // Live entries.
    logic             push;
    logic             pop;
    logic             empty;
    bp_pkg::addr_t    push_pc;

    assign push = res_valid & res_is_call;
    assign pop = res_valid & res_is_return;
    assign empty = (count == '0);
    assign push_pc = res_pc + bp_pkg::pc_step;                         // Return lands after call.
    assign ptr_up = (top_ptr == last_slot) ? '0 : top_ptr + 1'b1;
    assign ptr_dn = (top_ptr == '0) ? last_slot : top_ptr - 1'b1;

    // *********************************************************
    // Pointer and occupancy
    // *********************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '0;
            count <= '0;
        end else if (push && pop) begin
            if (empty) begin
                count <= cnt_w'(1);             // Replace on empty leaves one entry.
            end
        end else if (push) begin
            top_ptr <= ptr_up;
            if (count != full_count) begin
                count <= count + 1'b1;          // Full stack drops the oldest.
            end
        end else if (pop && !empty) begin
            top_ptr <= ptr_dn;
            count <= count - 1'b1;
        end
    end

    // Call and return together swap the top entry in place.
    always_ff @(posedge clk) begin
        if (push) begin
            stack_mem[pop ? top_ptr : ptr_up] <= push_pc;
        end
    end

    assign ras_top = empty ? bp_pkg::reset_vec : stack_mem[top_ptr];   // Idle value.

    // Program order must never return more often than it called.
    a_no_empty_pop: assert property (@(posedge clk) disable iff (rst)
        pop && !push |-> !empty)
        else $error("return resolved with an empty stack");

endmodule

`default_nettype wire

// File: rtl/branch_table.sv
// Direct-mapped branch target table with hit and misprediction detection and counters.
`timescale 1ns/1ns
`default_nettype none

module branch_table #(
    parameter int table_entries = 64,
    parameter bit use_predictor = 1'b1
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_accept,
    input  bp_pkg::addr_t  accept_pc,
    input  bp_pkg::addr_t  if_pc,
    input  logic           res_valid,
    input  bp_pkg::addr_t  res_pc,
    input  logic           res_taken,
    input  bp_pkg::addr_t  res_target,
    input  logic           res_is_return,
    input  bp_pkg::addr_t  res_next_pc,
    output logic           hit,
    output logic           use_ras,
    output bp_pkg::addr_t  predicted_pc,
    output logic           flush,
    output bp_pkg::addr_t  redirect_pc,
    output bp_pkg::count_t mispredict_branch_count,
    output bp_pkg::count_t mispredict_return_count
);

    localparam int idx_w = $clog2(table_entries);               // Index bits above the byte offset.
    localparam int tag_w = bp_pkg::tag_span_w - idx_w;          // Remaining upper bits.
    localparam int entry_w = bp_pkg::entry_flag_w + tag_w;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic             use_ras;
    } entry_t;

    logic [entry_w-1:0] tag_mem [table_entries];               // Valid, tag, return flag.
    bp_pkg::addr_t      target_mem [table_entries];            // Stored successor.

    entry_t             rd_entry;       // Entry of the last accepted PC.
    entry_t             wr_entry;       // Entry built from the resolution.
    bp_pkg::addr_t      rd_target;      // Target of the last accepted PC.
    logic [idx_w-1:0]   rd_idx;
    logic [idx_w-1:0]   wr_idx;
    bp_pkg::addr_t      seq_pc;         // Fall-through of the resolved PC.
    bp_pkg::addr_t      correct_pc;     // Architectural successor.
    logic               tag_match;
    logic               mispredict;

    // *********************************************************
    // Table memories
    // *********************************************************
    initial begin
        for (int i = 0; i < table_entries; i++) begin
            tag_mem[i] = '0;                        // All entries invalid.
            target_mem[i] = bp_pkg::reset_vec;
        end
    end

    assign rd_idx = accept_pc[bp_pkg::word_lsb +: idx_w];      // Fetch side index.
    assign wr_idx = res_pc[bp_pkg::word_lsb +: idx_w];         // Resolve side index.
    assign seq_pc = res_pc + bp_pkg::pc_step;
    assign correct_pc = res_taken ? res_target : seq_pc;

    // Remember the last outcome of this branch.
    assign wr_entry.valid = 1'b1;
    assign wr_entry.tag = res_pc[bp_pkg::addr_w-1 -: tag_w];
    assign wr_entry.use_ras = res_is_return;                    // Returns follow the stack.

    always_ff @(posedge clk) begin
        if (res_valid) begin
            tag_mem[wr_idx] <= wr_entry;
            target_mem[wr_idx] <= correct_pc;
        end
    end

    // Registered read, result seen the cycle after acceptance.
    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            rd_entry <= tag_mem[rd_idx];
            rd_target <= target_mem[rd_idx];
        end
    end

    // *********************************************************
    // Prediction and misprediction
    // *********************************************************
    assign tag_match = rd_entry.valid &&
                       (rd_entry.tag == if_pc[bp_pkg::addr_w-1 -: tag_w]);   // Same branch.
    assign mispredict = res_valid && (res_next_pc != correct_pc);           // Fetch went astray.

    if (use_predictor) begin : g_predict
        assign hit = tag_match;
        assign flush = mispredict;                  // Only wrong guesses redirect.
    end else begin : g_static
        assign hit = 1'b0;                          // Always fall through.
        assign flush = res_valid & res_taken;       // Every taken branch redirects.
    end

    assign use_ras = rd_entry.use_ras;
    assign predicted_pc = rd_target;
    assign redirect_pc = correct_pc;

    // Counters split by the return flag.
    always_ff @(posedge clk) begin
        if (rst) begin
            mispredict_branch_count <= '0;
        end else if (mispredict && !res_is_return) begin
            mispredict_branch_count <= mispredict_branch_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mispredict_return_count <= '0;
        end else if (mispredict && res_is_return) begin
            mispredict_return_count <= mispredict_return_count + 1'b1;
        end
    end

    // *********************************************************
    // Checks
    // *********************************************************
    // Index and tag skip the byte offset, so a misaligned branch would alias.
    a_res_aligned: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> (res_pc[bp_pkg::word_lsb-1:0] == '0) &&
                      (res_target[bp_pkg::word_lsb-1:0] == '0))
        else $error("resolution with a misaligned address");

endmodule

`default_nettype wire

// File: rtl/bp_pkg.sv
// Shared address, counter and table layout definitions for the next-PC predictor.
`default_nettype none

package bp_pkg;

    // *********************************************************
    // Address layout
    // *********************************************************
    parameter int addr_w = 32;                    // Instruction address width.
    parameter int word_lsb = 2;                   // Byte offset bits within a word.
    parameter int tag_span_w = addr_w - word_lsb; // Index plus tag bits.

    typedef logic [addr_w-1:0] addr_t;

    parameter addr_t pc_step = 32'd4;             // Sequential fetch stride.
    parameter addr_t reset_vec = 32'h0000_0200;   // First fetch after reset.

    // *********************************************************
    // Misprediction counters
    // *********************************************************
    parameter int count_w = 32;

    typedef logic [count_w-1:0] count_t;

    // *********************************************************
    // Branch table entry layout
    // *********************************************************
    // An entry holds a valid bit, the address tag and the return flag.
    // The tag width depends on the table size, so only the fixed
    // part of the entry is defined here.
    parameter int entry_flag_w = 2;               // Valid bit plus use_ras bit.

endpackage

`default_nettype wire
